// ==== pmp_pkg.sv ====
/* PMP shared definitions */
package pmp_pkg;

  // Implemented entries
  localparam int pmp_entries = 8;

  // MMU page number, PA bits 39 to 12
  localparam int pa_width = 28;

  // Stored address, write-data bits 38 to 10
  localparam int pmpaddr_width = 29;
  localparam int pmpaddr_lsb = 10;

  localparam int csr_data_width = 64;
  localparam int reg_num_width = 5;
  localparam int cfg_byte_width = 8;
  localparam int flg_width = 4;

  // Register numbers within the 0x3A0 CSR space
  localparam logic [reg_num_width-1:0] csr_pmpcfg0 = 5'd0;
  localparam logic [reg_num_width-1:0] csr_pmpcfg2 = 5'd2;
  localparam logic [reg_num_width-1:0] csr_pmpaddr_base = 5'd16;

  // Configuration byte layout
  localparam int cfg_r_bit = 0;
  localparam int cfg_w_bit = 1;
  localparam int cfg_x_bit = 2;
  localparam int cfg_a_lsb = 3;
  localparam int cfg_a_width = 2;
  localparam int cfg_l_bit = 7;
  // Bits 6 and 5 hardwired to zero
  localparam logic [cfg_byte_width-1:0] cfg_wr_mask = 8'h9f;

  // Address matching modes
  localparam logic [cfg_a_width-1:0] a_off = 2'd0;
  localparam logic [cfg_a_width-1:0] a_tor = 2'd1;
  localparam logic [cfg_a_width-1:0] a_na4 = 2'd2;
  localparam logic [cfg_a_width-1:0] a_napot = 2'd3;

  // Privilege levels
  localparam logic [1:0] priv_u = 2'd0;
  localparam logic [1:0] priv_s = 2'd1;
  localparam logic [1:0] priv_m = 2'd3;

  // Port flag, hit above x, w, r
  localparam int flg_hit_bit = 3;

endpackage

// ==== pmp_entry_match.sv ====
/* PMP entry address match */
module pmp_entry_match
  import pmp_pkg::*;
(
  input  logic [pa_width-1:0]      pa,
  input  logic [cfg_a_width-1:0]   addr_mode,
  input  logic [pmpaddr_width-1:0] pmpaddr_value,
  input  logic [pmpaddr_width-1:0] pmpaddr_prev,
  output logic                     match
);

  logic [pmpaddr_width-1:0] pa_ext;
  logic [pmpaddr_width-1:0] napot_mask;
  logic                     tor_match;
  logic                     napot_match;

  // Page number widened to stored address width
  assign pa_ext = {{(pmpaddr_width - pa_width){1'b0}}, pa};

  // Top of range, previous entry is the base
  assign tor_match = (pa_ext >= pmpaddr_prev) && (pa_ext < pmpaddr_value);

  // Trailing ones plus the first zero are don't care
  // k trailing ones give 2^(k+1) pages
  assign napot_mask = ~(pmpaddr_value ^ (pmpaddr_value + 1'b1));
  assign napot_match = (pa_ext & napot_mask) == (pmpaddr_value & napot_mask);

  always_comb begin
    unique case (addr_mode)
      a_tor:   match = tor_match;
      a_napot: match = napot_match;
      // NA4 below the 4 KiB granule, never hits
      a_off, a_na4: match = 1'b0;
      default: match = 1'b0;
    endcase
  end

endmodule

// ==== pmp_regs.sv ====
/* PMP configuration and address registers */
module pmp_regs
  import pmp_pkg::*;
(
  input  logic                      forever_cpuclk,
  input  logic                      rst_n,
  input  logic                      cp0_pmp_wreg,
  input  logic [reg_num_width-1:0]  cp0_pmp_reg_num,
  input  logic [csr_data_width-1:0] cp0_pmp_wdata,
  output logic [csr_data_width-1:0] pmp_cp0_data,
  output logic [csr_data_width-1:0] pmpcfg0_value,
  output logic [pmpaddr_width-1:0]  pmpaddr0_value,
  output logic [pmpaddr_width-1:0]  pmpaddr1_value,
  output logic [pmpaddr_width-1:0]  pmpaddr2_value,
  output logic [pmpaddr_width-1:0]  pmpaddr3_value,
  output logic [pmpaddr_width-1:0]  pmpaddr4_value,
  output logic [pmpaddr_width-1:0]  pmpaddr5_value,
  output logic [pmpaddr_width-1:0]  pmpaddr6_value,
  output logic [pmpaddr_width-1:0]  pmpaddr7_value
);

  logic [csr_data_width-1:0]                pmpcfg0_q;
  logic [pmp_entries-1:0][pmpaddr_width-1:0] pmpaddr_q;
  logic                                     cfg0_wen;
  logic [pmp_entries-1:0]                   addr_sel;
  logic [pmp_entries-1:0]                   addr_wen;
  logic [pmp_entries-1:0]                   cfg_lock;
  logic [pmp_entries-1:0]                   tor_lock;
  logic [pmp_entries-1:0]                   addr_lock;

  // Register number decode
  assign cfg0_wen = cp0_pmp_wreg && (cp0_pmp_reg_num == csr_pmpcfg0);
  assign addr_wen = addr_sel & {pmp_entries{cp0_pmp_wreg}};

  // Per-entry select and lock bits
  always_comb begin
    for (int i = 0; i < pmp_entries; i++) begin
      addr_sel[i] = cp0_pmp_reg_num == reg_num_width'(csr_pmpaddr_base + i);
      cfg_lock[i] = pmpcfg0_q[cfg_byte_width*i + cfg_l_bit];
      tor_lock[i] = cfg_lock[i] &&
        (pmpcfg0_q[cfg_byte_width*i + cfg_a_lsb +: cfg_a_width] == a_tor);
    end
  end

  // Address frozen by own lock or by a locked TOR entry above it
  assign addr_lock = cfg_lock | (tor_lock >> 1);

  // Config bytes written one by one, locked bytes kept
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      pmpcfg0_q <= '0;
    end else if (cfg0_wen) begin
      for (int i = 0; i < pmp_entries; i++) begin
        if (!cfg_lock[i]) begin
          pmpcfg0_q[cfg_byte_width*i +: cfg_byte_width] <=
            cp0_pmp_wdata[cfg_byte_width*i +: cfg_byte_width] & cfg_wr_mask;
        end
      end
    end
  end

  // Address registers, 4 KiB granule
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      pmpaddr_q <= '0;
    end else begin
      for (int i = 0; i < pmp_entries; i++) begin
        if (addr_wen[i] && !addr_lock[i]) begin
          pmpaddr_q[i] <= cp0_pmp_wdata[pmpaddr_lsb +: pmpaddr_width];
        end
      end
    end
  end

  assign pmpcfg0_value  = pmpcfg0_q;
  assign pmpaddr0_value = pmpaddr_q[0];
  assign pmpaddr1_value = pmpaddr_q[1];
  assign pmpaddr2_value = pmpaddr_q[2];
  assign pmpaddr3_value = pmpaddr_q[3];
  assign pmpaddr4_value = pmpaddr_q[4];
  assign pmpaddr5_value = pmpaddr_q[5];
  assign pmpaddr6_value = pmpaddr_q[6];
  assign pmpaddr7_value = pmpaddr_q[7];

  // Read mux, unimplemented numbers give zero
  always_comb begin
    pmp_cp0_data = '0;
    if (cp0_pmp_reg_num == csr_pmpcfg0) begin
      pmp_cp0_data = pmpcfg0_q;
    end else if (cp0_pmp_reg_num == csr_pmpcfg2) begin
      // Entries 8 to 15 not implemented
      pmp_cp0_data = '0;
    end else begin
      for (int i = 0; i < pmp_entries; i++) begin
        if (addr_sel[i]) begin
          pmp_cp0_data[pmpaddr_lsb +: pmpaddr_width] = pmpaddr_q[i];
        end
      end
    end
  end

  // Single register written per strobe
  wen_onehot_chk: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    $onehot0({cfg0_wen, addr_wen}))
    else $error("more than one PMP register write-enabled");

  // Locked config byte survives a write
  for (genvar g = 0; g < pmp_entries; g++) begin : g_lock_chk
    cfg_lock_chk: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
      cfg0_wen && cfg_lock[g] |=> $stable(pmpcfg0_q[cfg_byte_width*g +: cfg_byte_width]))
      else $error("locked pmpcfg byte %0d changed", g);
  end

endmodule

// ==== pmp_acc.sv ====
/* PMP per-port permission check */
module pmp_acc
  import pmp_pkg::*;
(
  input  logic [1:0]                cp0_pmp_mpp,
  input  logic [1:0]                cur_priv_mode,
  input  logic                      pmp_mprv_status,
  input  logic [pa_width-1:0]       mmu_pmp_pa,
  input  logic [csr_data_width-1:0] pmpcfg0_value,
  input  logic [pmpaddr_width-1:0]  pmpaddr0_value,
  input  logic [pmpaddr_width-1:0]  pmpaddr1_value,
  input  logic [pmpaddr_width-1:0]  pmpaddr2_value,
  input  logic [pmpaddr_width-1:0]  pmpaddr3_value,
  input  logic [pmpaddr_width-1:0]  pmpaddr4_value,
  input  logic [pmpaddr_width-1:0]  pmpaddr5_value,
  input  logic [pmpaddr_width-1:0]  pmpaddr6_value,
  input  logic [pmpaddr_width-1:0]  pmpaddr7_value,
  output logic [flg_width-1:0]      pmp_mmu_flg
);

  logic [pmp_entries-1:0][pmpaddr_width-1:0] addr_vec;
  logic [pmp_entries-1:0]                   match_vec;
  logic [1:0]                               eff_priv;
  logic [cfg_byte_width-1:0]                hit_cfg;
  logic                                     hit;
  logic [flg_hit_bit-1:0]                   xwr;

  assign addr_vec = {pmpaddr7_value, pmpaddr6_value, pmpaddr5_value, pmpaddr4_value,
                     pmpaddr3_value, pmpaddr2_value, pmpaddr1_value, pmpaddr0_value};

  // One matcher per entry
  for (genvar g = 0; g < pmp_entries; g++) begin : g_entry
    logic [pmpaddr_width-1:0] prev;

    // Entry 0 has a zero base for TOR
    if (g == 0) begin : g_first
      assign prev = '0;
    end else begin : g_rest
      assign prev = addr_vec[g-1];
    end

    pmp_entry_match x_entry_match (
      .pa            (mmu_pmp_pa),
      .addr_mode     (pmpcfg0_value[cfg_byte_width*g + cfg_a_lsb +: cfg_a_width]),
      .pmpaddr_value (addr_vec[g]),
      .pmpaddr_prev  (prev),
      .match         (match_vec[g])
    );
  end

  // MPRV swaps in MPP for M-mode data accesses
  assign eff_priv = (pmp_mprv_status && (cur_priv_mode == priv_m)) ?
                    cp0_pmp_mpp : cur_priv_mode;

  assign hit = |match_vec;

  // Lowest entry wins, scan from the top down
  always_comb begin
    hit_cfg = '0;
    for (int i = pmp_entries - 1; i >= 0; i--) begin
      if (match_vec[i]) begin
        hit_cfg = pmpcfg0_value[cfg_byte_width*i +: cfg_byte_width];
      end
    end
  end

  // Permission bits
  always_comb begin
    if (hit) begin
      // Unlocked entries do not bind M mode
      if ((eff_priv == priv_m) && !hit_cfg[cfg_l_bit]) begin
        xwr = '1;
      end else begin
        xwr = {hit_cfg[cfg_x_bit], hit_cfg[cfg_w_bit], hit_cfg[cfg_r_bit]};
      end
    end else if (eff_priv == priv_m) begin
      xwr = '1;
    end else begin
      xwr = '0;
    end
  end

  assign pmp_mmu_flg[flg_hit_bit]     = hit;
  assign pmp_mmu_flg[flg_hit_bit-1:0] = xwr;

  // Miss on the port flag gives full access to M, none to S and U
  always_comb begin
    if (!pmp_mmu_flg[flg_hit_bit] && (eff_priv == priv_m)) begin
      miss_m_chk: assert ((match_vec == '0) && (pmp_mmu_flg[flg_hit_bit-1:0] == 3'b111))
        else $error("M-mode miss flag %b without full access", pmp_mmu_flg);
    end
    if (!pmp_mmu_flg[flg_hit_bit] && ((eff_priv == priv_s) || (eff_priv == priv_u))) begin
      miss_su_chk: assert ((match_vec == '0) && (pmp_mmu_flg[flg_hit_bit-1:0] == 3'b000))
        else $error("S/U-mode miss flag %b with access granted", pmp_mmu_flg);
    end
  end

endmodule

// ==== pmp_top.sv ====
/* PMP top level */
module pmp_top
  import pmp_pkg::*;
(
  input  logic                      forever_cpuclk,
  input  logic                      rst_n,
  input  logic                      cp0_pmp_wreg,
  input  logic [reg_num_width-1:0]  cp0_pmp_reg_num,
  input  logic [csr_data_width-1:0] cp0_pmp_wdata,
  input  logic [1:0]                cp0_yy_priv_mode,
  input  logic [1:0]                cp0_pmp_mpp,
  input  logic                      cp0_pmp_mprv,
  input  logic                      mmu_pmp_fetch3,
  input  logic [pa_width-1:0]       mmu_pmp_pa0,
  input  logic [pa_width-1:0]       mmu_pmp_pa1,
  input  logic [pa_width-1:0]       mmu_pmp_pa2,
  input  logic [pa_width-1:0]       mmu_pmp_pa3,
  input  logic [pa_width-1:0]       mmu_pmp_pa4,
  output logic [csr_data_width-1:0] pmp_cp0_data,
  output logic [flg_width-1:0]      pmp_mmu_flg0,
  output logic [flg_width-1:0]      pmp_mmu_flg1,
  output logic [flg_width-1:0]      pmp_mmu_flg2,
  output logic [flg_width-1:0]      pmp_mmu_flg3,
  output logic [flg_width-1:0]      pmp_mmu_flg4
);

  logic [1:0]                cur_priv_mode;
  logic [csr_data_width-1:0] pmpcfg0_value;
  logic [pmpaddr_width-1:0]  pmpaddr0_value;
  logic [pmpaddr_width-1:0]  pmpaddr1_value;
  logic [pmpaddr_width-1:0]  pmpaddr2_value;
  logic [pmpaddr_width-1:0]  pmpaddr3_value;
  logic [pmpaddr_width-1:0]  pmpaddr4_value;
  logic [pmpaddr_width-1:0]  pmpaddr5_value;
  logic [pmpaddr_width-1:0]  pmpaddr6_value;
  logic [pmpaddr_width-1:0]  pmpaddr7_value;
  logic                      pmp_mprv_status0;
  logic                      pmp_mprv_status1;
  logic                      pmp_mprv_status2;
  logic                      pmp_mprv_status3;
  logic                      pmp_mprv_status4;

  assign cur_priv_mode = cp0_yy_priv_mode;

  // MPRV per port
  assign pmp_mprv_status0 = cp0_pmp_mprv;
  assign pmp_mprv_status1 = cp0_pmp_mprv;
  // Instruction fetch ignores MPRV
  assign pmp_mprv_status2 = 1'b0;
  // Shared port, fetch requests ignore MPRV
  assign pmp_mprv_status3 = cp0_pmp_mprv && !mmu_pmp_fetch3;
  assign pmp_mprv_status4 = cp0_pmp_mprv;

  // CSR storage
  pmp_regs x_pmp_regs (.*);

  // Checkers share the register values
  pmp_acc x_pmp_acc0 (
    .mmu_pmp_pa      (mmu_pmp_pa0),
    .pmp_mprv_status (pmp_mprv_status0),
    .pmp_mmu_flg     (pmp_mmu_flg0),
    .*
  );

  pmp_acc x_pmp_acc1 (
    .mmu_pmp_pa      (mmu_pmp_pa1),
    .pmp_mprv_status (pmp_mprv_status1),
    .pmp_mmu_flg     (pmp_mmu_flg1),
    .*
  );

  pmp_acc x_pmp_acc2 (
    .mmu_pmp_pa      (mmu_pmp_pa2),
    .pmp_mprv_status (pmp_mprv_status2),
    .pmp_mmu_flg     (pmp_mmu_flg2),
    .*
  );

  pmp_acc x_pmp_acc3 (
    .mmu_pmp_pa      (mmu_pmp_pa3),
    .pmp_mprv_status (pmp_mprv_status3),
    .pmp_mmu_flg     (pmp_mmu_flg3),
    .*
  );

  pmp_acc x_pmp_acc4 (
    .mmu_pmp_pa      (mmu_pmp_pa4),
    .pmp_mprv_status (pmp_mprv_status4),
    .pmp_mmu_flg     (pmp_mmu_flg4),
    .*
  );

endmodule

// ==== pmp_ref.svh ====
/* PMP reference model */
`ifndef PMP_REF_SVH
`define PMP_REF_SVH

// Model copy of pmpcfg0 and the address registers
logic [csr_data_width-1:0] model_cfg;
logic [pmpaddr_width-1:0]  model_addr [pmp_entries];

task automatic clear_model();
  model_cfg = '0;
  for (int i = 0; i < pmp_entries; i++) begin
    model_addr[i] = '0;
  end
endtask

// Address i frozen by its own lock or a locked TOR entry above
function automatic logic addr_frozen(input int i);
  logic [7:0] above;
  if (model_cfg[8*i + cfg_l_bit]) begin
    return 1'b1;
  end
  if (i + 1 >= pmp_entries) begin
    return 1'b0;
  end
  above = model_cfg[8*(i+1) +: 8];
  return above[cfg_l_bit] && (above[cfg_a_lsb +: 2] == a_tor);
endfunction

task automatic update_model(input logic [4:0] num, input logic [63:0] data);
  logic [7:0] cur;
  logic [7:0] nxt;
  int         idx;
  idx = int'(num) - int'(csr_pmpaddr_base);
  if (num == csr_pmpcfg0) begin
    for (int i = 0; i < pmp_entries; i++) begin
      cur = model_cfg[8*i +: 8];
      nxt = data[8*i +: 8];
      // Reserved bits read zero
      nxt[6] = 1'b0;
      nxt[5] = 1'b0;
      if (!cur[cfg_l_bit]) begin
        model_cfg[8*i +: 8] = nxt;
      end
    end
  end else if (idx >= 0 && idx < pmp_entries) begin
    if (!addr_frozen(idx)) begin
      model_addr[idx] = data[38:10];
    end
  end
endtask

function automatic logic [63:0] expected_read(input logic [4:0] num);
  logic [63:0] val;
  int          idx;
  idx = int'(num) - int'(csr_pmpaddr_base);
  val = '0;
  if (num == csr_pmpcfg0) begin
    val = model_cfg;
  end else if (idx >= 0 && idx < pmp_entries) begin
    val[38:10] = model_addr[idx];
  end
  return val;
endfunction

function automatic logic entry_hit(input int i, input logic [pa_width-1:0] pa);
  logic [1:0]  mode;
  logic [28:0] page;
  logic [28:0] top;
  logic [28:0] base;
  int          k;
  mode = model_cfg[8*i + cfg_a_lsb +: 2];
  page = {1'b0, pa};
  top  = model_addr[i];
  base = '0;
  if (i > 0) begin
    base = model_addr[i-1];
  end
  // Trailing ones of the NAPOT address
  k = 0;
  while (k < pmpaddr_width && top[k]) begin
    k++;
  end
  case (mode)
    a_tor:   return (page >= base) && (page < top);
    a_napot: return (page >> (k + 1)) == (top >> (k + 1));
    default: return 1'b0;
  endcase
endfunction

// Expected flag {hit, x, w, r} for one port
function automatic logic [3:0] ref_flag(input logic [pa_width-1:0] pa, input logic [1:0] priv,
                                        input logic [1:0] mpp, input logic mprv);
  logic [1:0] eff;
  logic [7:0] cfg;
  eff = (mprv && (priv == priv_m)) ? mpp : priv;
  for (int i = 0; i < pmp_entries; i++) begin
    if (entry_hit(i, pa)) begin
      cfg = model_cfg[8*i +: 8];
      if ((eff == priv_m) && !cfg[cfg_l_bit]) begin
        return 4'b1111;
      end
      return {1'b1, cfg[cfg_x_bit], cfg[cfg_w_bit], cfg[cfg_r_bit]};
    end
  end
  return (eff == priv_m) ? 4'b0111 : 4'b0000;
endfunction

`endif

// ==== pmp_tb.sv ====
/* PMP testbench */
module pmp_tb
  import pmp_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int reset_cycles = 10;
  localparam int rounds = 40;
  localparam int accesses = 8;
  localparam int planned_cycles = reset_cycles + 32 + 65 + rounds * (1 + pmp_entries + accesses)
                                  + 60 + 30 + 30;

  logic                           clk;
  logic                           rst_n;
  logic                           wreg;
  logic [reg_num_width-1:0]       reg_num;
  logic [csr_data_width-1:0]      wdata;
  logic [1:0]                     priv_mode;
  logic [1:0]                     mpp;
  logic                           mprv;
  logic                           fetch3;
  logic [4:0][pa_width-1:0]       pa;
  logic [4:0][flg_width-1:0]      flg;
  logic [csr_data_width-1:0]      rdata;
  logic                           check_en;
  int                             errors;
  int                             checks;
  integer                         seed = 32'he761;

  `include "pmp_ref.svh"

  pmp_top dut_i (
    .forever_cpuclk   (clk),
    .rst_n            (rst_n),
    .cp0_pmp_wreg     (wreg),
    .cp0_pmp_reg_num  (reg_num),
    .cp0_pmp_wdata    (wdata),
    .cp0_yy_priv_mode (priv_mode),
    .cp0_pmp_mpp      (mpp),
    .cp0_pmp_mprv     (mprv),
    .mmu_pmp_fetch3   (fetch3),
    .mmu_pmp_pa0      (pa[0]),
    .mmu_pmp_pa1      (pa[1]),
    .mmu_pmp_pa2      (pa[2]),
    .mmu_pmp_pa3      (pa[3]),
    .mmu_pmp_pa4      (pa[4]),
    .pmp_cp0_data     (rdata),
    .pmp_mmu_flg0     (flg[0]),
    .pmp_mmu_flg1     (flg[1]),
    .pmp_mmu_flg2     (flg[2]),
    .pmp_mmu_flg3     (flg[3]),
    .pmp_mmu_flg4     (flg[4])
  );

  always #50 clk = ~clk;

  // Port 2 is fetch only, port 3 shares fetch and data
  function automatic logic port_mprv(input int p);
    case (p)
      2:       return 1'b0;
      3:       return mprv && !fetch3;
      default: return mprv;
    endcase
  endfunction

  function automatic logic [1:0] priv_of(input int i);
    case (i % 3)
      0:       return priv_u;
      1:       return priv_s;
      default: return priv_m;
    endcase
  endfunction

  function automatic logic [1:0] rand_priv();
    logic [31:0] r;
    r = $random(seed);
    return priv_of(int'(r[7:0]));
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic write_reg(input logic [4:0] num, input logic [63:0] data);
    wreg = 1'b1;
    reg_num = num;
    wdata = data;
    next_cycle();
    wreg = 1'b0;
  endtask

  // Random pages in a window, random MPRV inputs
  task automatic rand_access(input logic [1:0] priv, input logic [pa_width-1:0] mask);
    logic [31:0] r;
    for (int p = 0; p < 5; p++) begin
      r = $random(seed);
      pa[p] = r[pa_width-1:0] & mask;
    end
    r = $random(seed);
    priv_mode = priv;
    mpp = rand_priv();
    mprv = r[0];
    fetch3 = r[1];
  endtask

  // Model follows the DUT registers on the same edge
  always @(posedge clk) begin
    if (!rst_n) begin
      clear_model();
    end else if (wreg) begin
      update_model(reg_num, wdata);
    end
  end

  // Compare at the falling edge
  always @(negedge clk) begin
    logic [flg_width-1:0]      exp_flg;
    logic [csr_data_width-1:0] exp_data;
    if (check_en) begin
      for (int p = 0; p < 5; p++) begin
        exp_flg = ref_flag(pa[p], priv_mode, mpp, port_mprv(p));
        checks++;
        flag_chk: assert (flg[p] === exp_flg)
          else begin
            errors++;
            $display("FAIL %0t: port %0d pa %h priv %0d flag %b, expected %b",
                     $time, p, pa[p], priv_mode, flg[p], exp_flg);
          end
      end
      exp_data = expected_read(reg_num);
      checks++;
      data_chk: assert (rdata === exp_data)
        else begin
          errors++;
          $display("FAIL %0t: reg %0d read %h, expected %h", $time, reg_num, rdata, exp_data);
        end
    end
  end

  initial begin
    #(planned_cycles * 2 * 100);
    $display("Watchdog: run timed out after %0d cycles", planned_cycles * 2);
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [63:0] data;
    clk = 1'b0;
    rst_n = 1'b0;
    wreg = 1'b0;
    reg_num = '0;
    wdata = '0;
    priv_mode = priv_m;
    mpp = priv_u;
    mprv = 1'b0;
    fetch3 = 1'b0;
    pa = '0;
    check_en = 1'b0;
    errors = 0;
    checks = 0;
    repeat (reset_cycles) next_cycle();
    rst_n = 1'b1;
    check_en = 1'b1;

    // Reset state, all numbers read zero
    for (int n = 0; n < 32; n++) begin
      reg_num = 5'(n);
      rand_access(priv_of(n), 28'hfff);
      next_cycle();
    end

    // Write and read back every number, locks kept off
    for (int n = 0; n < 32; n++) begin
      data = {$random(seed), $random(seed)};
      if (n == 0) begin
        data = data & 64'h7f7f_7f7f_7f7f_7f7f;
      end
      write_reg(5'(n), data);
      next_cycle();
    end
    write_reg(csr_pmpcfg0, '0);

    // Random TOR, NAPOT and NA4 regions
    for (int k = 0; k < rounds; k++) begin
      data = {$random(seed), $random(seed)};
      write_reg(csr_pmpcfg0, data & 64'h7f7f_7f7f_7f7f_7f7f);
      for (int i = 0; i < pmp_entries; i++) begin
        r = $random(seed);
        write_reg(5'(csr_pmpaddr_base + i), {32'h0, r & 32'h003f_ffff});
      end
      for (int j = 0; j < accesses; j++) begin
        r = $random(seed);
        reg_num = r[4:0];
        rand_access(priv_of(j), 28'hfff);
        next_cycle();
      end
    end

    // Locked TOR entry 1 over 0x10..0x1f, locked NAPOT entry 3 over 0x40..0x4f
    write_reg(csr_pmpaddr_base, 64'h10 << 10);
    write_reg(5'(csr_pmpaddr_base + 1), 64'h20 << 10);
    write_reg(5'(csr_pmpaddr_base + 3), 64'h47 << 10);
    write_reg(csr_pmpcfg0, 64'h0000_0000_9c00_8900);
    for (int j = 0; j < 16; j++) begin
      rand_access(priv_m, 28'h7f);
      next_cycle();
    end
    // Frozen targets mixed with free ones
    write_reg(csr_pmpcfg0, 64'h1b1b_1b1b_1b1b_1b1b);
    next_cycle();
    for (int i = 0; i < 5; i++) begin
      write_reg(5'(csr_pmpaddr_base + i), 64'h7f << 10);
      next_cycle();
    end
    for (int j = 0; j < 8; j++) begin
      rand_access(priv_of(j), 28'h7f);
      next_cycle();
    end
    // Reset drops the locks
    rst_n = 1'b0;
    repeat (reset_cycles) next_cycle();
    rst_n = 1'b1;
    write_reg(5'(csr_pmpaddr_base + 1), 64'h33 << 10);
    next_cycle();

    // MPRV, entry 0 gives S and U read only over 0x000..0x3ff
    write_reg(csr_pmpaddr_base, 64'h1ff << 10);
    write_reg(csr_pmpcfg0, 64'h19);
    for (int j = 0; j < 24; j++) begin
      rand_access(priv_m, 28'h3ff);
      mprv = 1'b1;
      mpp = (j % 2 == 0) ? priv_s : priv_u;
      fetch3 = j[1];
      next_cycle();
    end

    // Write strobe against read data and flags
    for (int i = 0; i < pmp_entries; i++) begin
      r = $random(seed);
      rand_access(priv_of(i), 28'h3ff);
      write_reg(5'(csr_pmpaddr_base + i), {32'h0, r & 32'h000f_ffff});
      next_cycle();
    end
    write_reg(csr_pmpcfg0, 64'h1b19_0b0d_1f0c_1d0b);
    next_cycle();
    next_cycle();

    check_en = 1'b0;
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== pmp.f ====
+incdir+.
pmp_pkg.sv
pmp_entry_match.sv
pmp_regs.sv
pmp_acc.sv
pmp_top.sv
pmp_tb.sv

// ==== Makefile ====
# Verilator build and run of the PMP testbench

VERILATOR ?= verilator
TOP       ?= pmp_tb
FILELIST  ?= pmp.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= tests failed
VFLAGS    ?= --binary --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) pmp_ref.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG FAIL_MSG VFLAGS"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
